// File: all.f
+incdir+.
core_pkg.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
core_top.sv
tb_core.sv

// File: core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath and register file
`define CORE_XLEN     32
`define CORE_NREGS    32
`define CORE_RADDR_W  5

// Instruction fields
`define CORE_OPC_HI   31
`define CORE_OPC_LO   26
`define CORE_RD_LO    21
`define CORE_RJ_LO    16
`define CORE_RK_LO    11
`define CORE_IMM_W    16

// Byte distance between sequential instructions
`define CORE_PC_STEP  4

// Branch offset is in instruction units
`define CORE_BR_SHIFT 2

`endif

// File: core_pkg.sv
`include "core_macros.svh"

package core_pkg;

    // Instruction opcodes, any other encoding is a no-op
    typedef enum logic [`CORE_OPC_HI-`CORE_OPC_LO:0] {
        OPC_ADD  = 6'h01,
        OPC_SUB  = 6'h02,
        OPC_AND  = 6'h03,
        OPC_OR   = 6'h04,
        OPC_XOR  = 6'h05,
        OPC_SLT  = 6'h06,
        OPC_ADDI = 6'h08,
        OPC_LUI  = 6'h09,
        OPC_BEQ  = 6'h10,
        OPC_BNE  = 6'h11
    } opcode_e;

    // ALU functions
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI   // Upper half load
    } alu_op_e;

    // Branch compare kinds
    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_e;

endpackage

// File: core_top.sv
`include "core_macros.svh"

module core_top (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     instr_valid_i,
    input  logic [`CORE_XLEN-1:0]    instr_i,
    input  logic [`CORE_XLEN-1:0]    pc_i,
    output logic                     redirect_o,
    output logic [`CORE_XLEN-1:0]    redirect_pc_o,
    output logic [`CORE_XLEN-1:0]    debug_wb_pc_o,
    output logic                     debug_wb_rf_wen_o,
    output logic [`CORE_RADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [`CORE_XLEN-1:0]    debug_wb_rf_wdata_o
);

    // Register file read ports
    logic [`CORE_RADDR_W-1:0] rj_addr;
    logic [`CORE_RADDR_W-1:0] rk_addr;
    logic [`CORE_XLEN-1:0]    rj_data;
    logic [`CORE_XLEN-1:0]    rk_data;

    // Decode to execute
    logic                     id_valid;
    logic [`CORE_XLEN-1:0]    id_pc;
    core_pkg::alu_op_e        id_alu_op;
    core_pkg::branch_e        id_branch;
    logic                     id_use_imm;
    logic [`CORE_XLEN-1:0]    id_imm;
    logic                     id_rf_we;
    logic [`CORE_RADDR_W-1:0] id_rd;
    logic [`CORE_RADDR_W-1:0] id_rj;
    logic [`CORE_RADDR_W-1:0] id_rk;
    logic [`CORE_XLEN-1:0]    id_rj_data;
    logic [`CORE_XLEN-1:0]    id_rk_data;

    // Execute to result
    logic                     ex_valid;
    logic [`CORE_XLEN-1:0]    ex_pc;
    logic                     ex_rf_we;
    logic [`CORE_RADDR_W-1:0] ex_rd;
    logic [`CORE_XLEN-1:0]    ex_data;

    decode_stage u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .redirect_i    (redirect_o),
        .rj_data_i     (rj_data),
        .rk_data_i     (rk_data),
        .rj_addr_o     (rj_addr),
        .rk_addr_o     (rk_addr),
        .id_valid_o    (id_valid),
        .id_pc_o       (id_pc),
        .id_alu_op_o   (id_alu_op),
        .id_branch_o   (id_branch),
        .id_use_imm_o  (id_use_imm),
        .id_imm_o      (id_imm),
        .id_rf_we_o    (id_rf_we),
        .id_rd_o       (id_rd),
        .id_rj_o       (id_rj),
        .id_rk_o       (id_rk),
        .id_rj_data_o  (id_rj_data),
        .id_rk_data_o  (id_rk_data)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .id_valid_i    (id_valid),
        .id_pc_i       (id_pc),
        .id_alu_op_i   (id_alu_op),
        .id_branch_i   (id_branch),
        .id_use_imm_i  (id_use_imm),
        .id_imm_i      (id_imm),
        .id_rf_we_i    (id_rf_we),
        .id_rd_i       (id_rd),
        .id_rj_i       (id_rj),
        .id_rk_i       (id_rk),
        .id_rj_data_i  (id_rj_data),
        .id_rk_data_i  (id_rk_data),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .ex_valid_o    (ex_valid),
        .ex_pc_o       (ex_pc),
        .ex_rf_we_o    (ex_rf_we),
        .ex_rd_o       (ex_rd),
        .ex_data_o     (ex_data)
    );

    result_stage u_result (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .ex_valid_i          (ex_valid),
        .ex_pc_i             (ex_pc),
        .ex_rf_we_i          (ex_rf_we),
        .ex_rd_i             (ex_rd),
        .ex_data_i           (ex_data),
        .rj_addr_i           (rj_addr),
        .rk_addr_i           (rk_addr),
        .rj_data_o           (rj_data),
        .rk_data_o           (rk_data),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

endmodule

// File: decode_stage.sv
`include "core_macros.svh"

module decode_stage (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     instr_valid_i,
    input  logic [`CORE_XLEN-1:0]    instr_i,
    input  logic [`CORE_XLEN-1:0]    pc_i,
    input  logic                     redirect_i,
    input  logic [`CORE_XLEN-1:0]    rj_data_i,
    input  logic [`CORE_XLEN-1:0]    rk_data_i,
    output logic [`CORE_RADDR_W-1:0] rj_addr_o,
    output logic [`CORE_RADDR_W-1:0] rk_addr_o,
    output logic                     id_valid_o,
    output logic [`CORE_XLEN-1:0]    id_pc_o,
    output core_pkg::alu_op_e        id_alu_op_o,
    output core_pkg::branch_e        id_branch_o,
    output logic                     id_use_imm_o,
    output logic [`CORE_XLEN-1:0]    id_imm_o,
    output logic                     id_rf_we_o,
    output logic [`CORE_RADDR_W-1:0] id_rd_o,
    output logic [`CORE_RADDR_W-1:0] id_rj_o,
    output logic [`CORE_RADDR_W-1:0] id_rk_o,
    output logic [`CORE_XLEN-1:0]    id_rj_data_o,
    output logic [`CORE_XLEN-1:0]    id_rk_data_o
);

    core_pkg::opcode_e         opcode;
    core_pkg::alu_op_e         alu_op;
    core_pkg::branch_e         branch;
    logic [`CORE_RADDR_W-1:0]  rd;
    logic [`CORE_RADDR_W-1:0]  rj;
    logic [`CORE_RADDR_W-1:0]  rk;
    logic [`CORE_IMM_W-1:0]    imm16;
    logic [`CORE_XLEN-1:0]     imm_sext;
    logic                      use_imm;
    logic                      writes_rd;

    assign opcode   = core_pkg::opcode_e'(instr_i[`CORE_OPC_HI:`CORE_OPC_LO]);
    assign rd       = instr_i[`CORE_RD_LO +: `CORE_RADDR_W];
    assign rj       = instr_i[`CORE_RJ_LO +: `CORE_RADDR_W];
    assign rk       = instr_i[`CORE_RK_LO +: `CORE_RADDR_W];
    assign imm16    = instr_i[`CORE_IMM_W-1:0];
    assign imm_sext = {{(`CORE_XLEN-`CORE_IMM_W){imm16[`CORE_IMM_W-1]}}, imm16};

    always_comb begin
        alu_op    = core_pkg::ALU_ADD;
        branch    = core_pkg::BR_NONE;
        use_imm   = 1'b0;
        writes_rd = 1'b1;
        case (opcode)
            core_pkg::OPC_ADD:  alu_op = core_pkg::ALU_ADD;
            core_pkg::OPC_SUB:  alu_op = core_pkg::ALU_SUB;
            core_pkg::OPC_AND:  alu_op = core_pkg::ALU_AND;
            core_pkg::OPC_OR:   alu_op = core_pkg::ALU_OR;
            core_pkg::OPC_XOR:  alu_op = core_pkg::ALU_XOR;
            core_pkg::OPC_SLT:  alu_op = core_pkg::ALU_SLT;
            core_pkg::OPC_ADDI: use_imm = 1'b1;
            core_pkg::OPC_LUI: begin
                alu_op  = core_pkg::ALU_LUI;
                use_imm = 1'b1;
            end
            core_pkg::OPC_BEQ: begin
                branch    = core_pkg::BR_EQ;
                writes_rd = 1'b0;
            end
            core_pkg::OPC_BNE: begin
                branch    = core_pkg::BR_NE;
                writes_rd = 1'b0;
            end
            default: writes_rd = 1'b0;   // Unknown opcode is a no-op
        endcase
    end

    // Branches compare rd against rj, so rd goes out on the rk port
    assign rj_addr_o = rj;
    assign rk_addr_o = (branch != core_pkg::BR_NONE) ? rd : rk;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_valid_o <= 1'b0;
        end else begin
            id_valid_o <= instr_valid_i && !redirect_i;  // Squash behind a taken branch
        end
    end

    always_ff @(posedge clk) begin
        id_pc_o      <= pc_i;
        id_alu_op_o  <= alu_op;
        id_branch_o  <= branch;
        id_use_imm_o <= use_imm;
        id_imm_o     <= imm_sext;
        id_rf_we_o   <= writes_rd && (rd != '0);  // r0 never written
        id_rd_o      <= rd;
        id_rj_o      <= rj_addr_o;
        id_rk_o      <= rk_addr_o;
        id_rj_data_o <= rj_data_i;
        id_rk_data_o <= rk_data_i;
    end

    a_no_branch_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        id_valid_o && (id_branch_o != core_pkg::BR_NONE) |-> !id_rf_we_o);

endmodule

// File: execute_stage.sv
`include "core_macros.svh"

module execute_stage (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     id_valid_i,
    input  logic [`CORE_XLEN-1:0]    id_pc_i,
    input  core_pkg::alu_op_e        id_alu_op_i,
    input  core_pkg::branch_e        id_branch_i,
    input  logic                     id_use_imm_i,
    input  logic [`CORE_XLEN-1:0]    id_imm_i,
    input  logic                     id_rf_we_i,
    input  logic [`CORE_RADDR_W-1:0] id_rd_i,
    input  logic [`CORE_RADDR_W-1:0] id_rj_i,
    input  logic [`CORE_RADDR_W-1:0] id_rk_i,
    input  logic [`CORE_XLEN-1:0]    id_rj_data_i,
    input  logic [`CORE_XLEN-1:0]    id_rk_data_i,
    output logic                     redirect_o,
    output logic [`CORE_XLEN-1:0]    redirect_pc_o,
    output logic                     ex_valid_o,
    output logic [`CORE_XLEN-1:0]    ex_pc_o,
    output logic                     ex_rf_we_o,
    output logic [`CORE_RADDR_W-1:0] ex_rd_o,
    output logic [`CORE_XLEN-1:0]    ex_data_o
);

    logic                  fwd_rj;
    logic                  fwd_rk;
    logic [`CORE_XLEN-1:0] src_j;
    logic [`CORE_XLEN-1:0] src_k;
    logic [`CORE_XLEN-1:0] alu_b;
    logic [`CORE_XLEN-1:0] alu_res;
    logic                  br_taken;

    // Previous instruction still sits in our own result register
    assign fwd_rj = ex_valid_o && ex_rf_we_o && (ex_rd_o == id_rj_i);
    assign fwd_rk = ex_valid_o && ex_rf_we_o && (ex_rd_o == id_rk_i);

    assign src_j = fwd_rj ? ex_data_o : id_rj_data_i;
    assign src_k = fwd_rk ? ex_data_o : id_rk_data_i;
    assign alu_b = id_use_imm_i ? id_imm_i : src_k;

    always_comb begin
        case (id_alu_op_i)
            core_pkg::ALU_SUB: alu_res = src_j - alu_b;
            core_pkg::ALU_AND: alu_res = src_j & alu_b;
            core_pkg::ALU_OR:  alu_res = src_j | alu_b;
            core_pkg::ALU_XOR: alu_res = src_j ^ alu_b;
            core_pkg::ALU_SLT: alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(src_j) < $signed(alu_b)};
            core_pkg::ALU_LUI: alu_res = {alu_b[`CORE_IMM_W-1:0], {`CORE_IMM_W{1'b0}}};
            default:           alu_res = src_j + alu_b;
        endcase
    end

    // rd arrives on the k operand for branches
    always_comb begin
        case (id_branch_i)
            core_pkg::BR_EQ: br_taken = (src_j == src_k);
            core_pkg::BR_NE: br_taken = (src_j != src_k);
            default:         br_taken = 1'b0;
        endcase
    end

    assign redirect_o    = id_valid_i && br_taken;
    assign redirect_pc_o = id_pc_i + (id_imm_i << `CORE_BR_SHIFT);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
            ex_rf_we_o <= 1'b0;
        end else begin
            ex_valid_o <= id_valid_i;
            ex_rf_we_o <= id_valid_i && id_rf_we_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o   <= id_pc_i;
        ex_rd_o   <= id_rd_i;
        ex_data_o <= alu_res;
    end

    a_redirect_src: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_o |-> id_valid_i && (id_branch_i != core_pkg::BR_NONE));

    // Instruction strobed alongside a taken branch never reaches execute
    a_squash_hole: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_o |=> !id_valid_i);

endmodule

// File: result_stage.sv
`include "core_macros.svh"

module result_stage (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     ex_valid_i,
    input  logic [`CORE_XLEN-1:0]    ex_pc_i,
    input  logic                     ex_rf_we_i,
    input  logic [`CORE_RADDR_W-1:0] ex_rd_i,
    input  logic [`CORE_XLEN-1:0]    ex_data_i,
    input  logic [`CORE_RADDR_W-1:0] rj_addr_i,
    input  logic [`CORE_RADDR_W-1:0] rk_addr_i,
    output logic [`CORE_XLEN-1:0]    rj_data_o,
    output logic [`CORE_XLEN-1:0]    rk_data_o,
    output logic [`CORE_XLEN-1:0]    debug_wb_pc_o,
    output logic                     debug_wb_rf_wen_o,
    output logic [`CORE_RADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [`CORE_XLEN-1:0]    debug_wb_rf_wdata_o
);

    logic [`CORE_XLEN-1:0] rf [`CORE_NREGS];
    logic                  wr_en;

    assign wr_en = ex_valid_i && ex_rf_we_i && (ex_rd_i != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                rf[i] <= '0;
            end
        end else if (wr_en) begin
            rf[ex_rd_i] <= ex_data_i;
        end
    end

    // Write-through covers the instruction two ahead
    assign rj_data_o = (rj_addr_i == '0)                ? '0 :
                       (wr_en && (ex_rd_i == rj_addr_i)) ? ex_data_i :
                                                           rf[rj_addr_i];
    assign rk_data_o = (rk_addr_i == '0)                ? '0 :
                       (wr_en && (ex_rd_i == rk_addr_i)) ? ex_data_i :
                                                           rf[rk_addr_i];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            debug_wb_rf_wen_o <= 1'b0;
        end else begin
            debug_wb_rf_wen_o <= wr_en;  // Low for branches, r0 and no-ops
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i) begin
            debug_wb_pc_o       <= ex_pc_i;
            debug_wb_rf_wnum_o  <= ex_rd_i;
            debug_wb_rf_wdata_o <= ex_data_i;
        end
    end

    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        rf[0] == '0);

endmodule

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Architectural state as the reference sees it
logic [`CORE_XLEN-1:0] shadow_rf [`CORE_NREGS];
logic                  ref_prev_taken;   // Last presented instruction redirected

function automatic void ref_reset();
    for (int i = 0; i < `CORE_NREGS; i++) begin
        shadow_rf[i] = '0;
    end
    ref_prev_taken = 1'b0;
endfunction

// Applies one presented instruction slot to the shadow state
function automatic void ref_step(
    input  logic                     valid,
    input  logic [`CORE_XLEN-1:0]    instr,
    input  logic [`CORE_XLEN-1:0]    pc,
    output logic                     live,
    output logic                     wen,
    output logic [`CORE_RADDR_W-1:0] wnum,
    output logic [`CORE_XLEN-1:0]    wdata,
    output logic                     redir,
    output logic [`CORE_XLEN-1:0]    rpc
);
    logic [5:0]            opc;
    logic [4:0]            rd;
    logic [4:0]            rj;
    logic [4:0]            rk;
    logic [15:0]           imm;
    logic [`CORE_XLEN-1:0] sext;
    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    logic [`CORE_XLEN-1:0] c;
    logic [`CORE_XLEN-1:0] res;
    logic                  writes;

    opc    = instr[31:26];
    rd     = instr[25:21];
    rj     = instr[20:16];
    rk     = instr[15:11];
    imm    = instr[15:0];
    sext   = {{16{imm[15]}}, imm};
    a      = shadow_rf[rj];
    b      = shadow_rf[rk];
    c      = shadow_rf[rd];
    res    = '0;
    writes = 1'b0;
    redir  = 1'b0;
    live   = valid && !ref_prev_taken;   // Slot behind a taken branch is dropped

    if (live) begin
        case (opc)
            core_pkg::OPC_ADD: begin
                res    = a + b;
                writes = 1'b1;
            end
            core_pkg::OPC_SUB: begin
                res    = a - b;
                writes = 1'b1;
            end
            core_pkg::OPC_AND: begin
                res    = a & b;
                writes = 1'b1;
            end
            core_pkg::OPC_OR: begin
                res    = a | b;
                writes = 1'b1;
            end
            core_pkg::OPC_XOR: begin
                res    = a ^ b;
                writes = 1'b1;
            end
            core_pkg::OPC_SLT: begin
                res    = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                writes = 1'b1;
            end
            core_pkg::OPC_ADDI: begin
                res    = a + sext;
                writes = 1'b1;
            end
            core_pkg::OPC_LUI: begin
                res    = {imm, 16'h0000};
                writes = 1'b1;
            end
            core_pkg::OPC_BEQ: redir = (c == a);   // Compare rd with rj
            core_pkg::OPC_BNE: redir = (c != a);
            default: writes = 1'b0;                // Unknown opcode
        endcase
    end

    wen   = writes && (rd != 5'd0);
    wnum  = rd;
    wdata = res;
    rpc   = pc + (sext << `CORE_BR_SHIFT);
    if (wen) begin
        shadow_rf[rd] = res;
    end
    ref_prev_taken = live && redir;
endfunction

`endif

// File: tb_core.sv
`include "core_macros.svh"

module tb_core;

    logic                     clk = 1'b0;
    logic                     rst_n_i;
    logic                     instr_valid_i;
    logic [`CORE_XLEN-1:0]    instr_i;
    logic [`CORE_XLEN-1:0]    pc_i;
    logic                     redirect_o;
    logic [`CORE_XLEN-1:0]    redirect_pc_o;
    logic [`CORE_XLEN-1:0]    debug_wb_pc_o;
    logic                     debug_wb_rf_wen_o;
    logic [`CORE_RADDR_W-1:0] debug_wb_rf_wnum_o;
    logic [`CORE_XLEN-1:0]    debug_wb_rf_wdata_o;

    `include "tb_ref_model.svh"

    // Expected results in flight, slot 0 was presented last
    logic                     p_live  [3];
    logic                     p_wen   [3];
    logic [`CORE_RADDR_W-1:0] p_wnum  [3];
    logic [`CORE_XLEN-1:0]    p_wdata [3];
    logic [`CORE_XLEN-1:0]    p_pc    [3];
    logic                     p_redir [3];
    logic [`CORE_XLEN-1:0]    p_rpc   [3];

    int                    errors;
    int                    checks;
    int                    pending;   // Live slots not yet seen at write-back
    logic [`CORE_XLEN-1:0] next_pc;

    core_top UUT (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .instr_valid_i       (instr_valid_i),
        .instr_i             (instr_i),
        .pc_i                (pc_i),
        .redirect_o          (redirect_o),
        .redirect_pc_o       (redirect_pc_o),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

    always #5 clk = ~clk;

    task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL at %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // Outputs are sampled mid-cycle, inputs change on the rising edge
    always @(negedge clk) begin
        if (!rst_n_i) begin
            ref_reset();
            for (int i = 0; i < 3; i++) begin
                p_live[i]  = 1'b0;
                p_wen[i]   = 1'b0;
                p_redir[i] = 1'b0;
            end
            pending = 0;
        end else begin
            // Branch now sitting in decode
            check_val(32'(redirect_o), 32'(p_live[0] && p_redir[0]), "redirect_o");
            if (p_live[0] && p_redir[0]) begin
                check_val(redirect_pc_o, p_rpc[0], "redirect_pc_o");
            end
            check_val(32'(debug_wb_rf_wen_o), 32'(p_live[2] && p_wen[2]), "debug_wb_rf_wen_o");
            if (p_live[2]) begin
                check_val(debug_wb_pc_o, p_pc[2], "debug_wb_pc_o");
                if (p_wen[2]) begin
                    check_val(32'(debug_wb_rf_wnum_o), 32'(p_wnum[2]), "debug_wb_rf_wnum_o");
                    check_val(debug_wb_rf_wdata_o, p_wdata[2], "debug_wb_rf_wdata_o");
                end
                pending--;
            end
            for (int i = 2; i > 0; i--) begin
                p_live[i]  = p_live[i-1];
                p_wen[i]   = p_wen[i-1];
                p_wnum[i]  = p_wnum[i-1];
                p_wdata[i] = p_wdata[i-1];
                p_pc[i]    = p_pc[i-1];
                p_redir[i] = p_redir[i-1];
                p_rpc[i]   = p_rpc[i-1];
            end
            ref_step(instr_valid_i, instr_i, pc_i, p_live[0], p_wen[0], p_wnum[0],
                     p_wdata[0], p_redir[0], p_rpc[0]);
            p_pc[0] = pc_i;
            if (p_live[0]) begin
                pending++;
            end
        end
    end

    function automatic logic [31:0] enc_r(input logic [5:0] opc, input logic [4:0] rd,
                                          input logic [4:0] rj, input logic [4:0] rk);
        return {opc, rd, rj, rk, 11'd0};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] opc, input logic [4:0] rd,
                                          input logic [4:0] rj, input logic [15:0] imm);
        return {opc, rd, rj, imm};
    endfunction

    function automatic logic [5:0] alu_opc(input int sel);
        case (sel)
            0:       return core_pkg::OPC_ADD;
            1:       return core_pkg::OPC_SUB;
            2:       return core_pkg::OPC_AND;
            3:       return core_pkg::OPC_OR;
            4:       return core_pkg::OPC_XOR;
            5:       return core_pkg::OPC_SLT;
            6:       return core_pkg::OPC_ADDI;
            default: return core_pkg::OPC_LUI;
        endcase
    endfunction

    // Random register or immediate ALU instruction
    function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rj,
                                             input logic [4:0] rk);
        logic [5:0] opc;
        opc = alu_opc($urandom_range(7, 0));
        if (opc == core_pkg::OPC_ADDI || opc == core_pkg::OPC_LUI) begin
            return enc_i(opc, rd, rj, 16'($urandom()));
        end
        return enc_r(opc, rd, rj, rk);
    endfunction

    task automatic issue(input logic [31:0] instr);
        @(posedge clk);
        instr_valid_i <= 1'b1;
        instr_i       <= instr;
        pc_i          <= next_pc;
        next_pc = next_pc + `CORE_PC_STEP;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid_i <= 1'b0;
            instr_i       <= $urandom();   // Garbage must not execute
        end
    endtask

    task automatic drain(input string name);
        int waited;
        waited = 0;
        idle(1);
        while (pending != 0 && waited < 20) begin
            idle(1);
            waited++;
        end
        if (pending != 0) begin
            errors++;
            $display("ERROR: pipeline did not drain within 20 cycles in test %s", name);
        end
    endtask

    task automatic finish_test(input int num, input string name, input int err0,
                               input int chk0);
        drain(name);
        $display("test %0d %s: %0d checks, %0d errors", num, name, checks - chk0,
                 errors - err0);
    endtask

    initial begin
        int         err0;
        int         chk0;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] prev1;
        logic [4:0] prev2;

        void'($urandom(49802));
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        next_pc       = 32'h1c00_0000;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;

        // Fill every register, then isolated ALU ops
        err0 = errors;
        chk0 = checks;
        for (int r = 1; r < `CORE_NREGS; r++) begin
            issue(enc_i(core_pkg::OPC_LUI, 5'(r), 5'd0, 16'($urandom())));
            idle(2);
            issue(enc_i(core_pkg::OPC_ADDI, 5'(r), 5'(r), 16'($urandom())));
            idle(2);
        end
        for (int n = 0; n < 60; n++) begin
            issue(rand_alu(5'($urandom_range(31, 1)), 5'($urandom()), 5'($urandom())));
            idle(2);
        end
        finish_test(1, "alu", err0, chk0);

        // Back-to-back chains on the last two destinations
        err0  = errors;
        chk0  = checks;
        prev1 = 5'd1;
        prev2 = 5'd2;
        for (int n = 0; n < 80; n++) begin
            rd = 5'($urandom_range(31, 1));
            if ($urandom_range(1, 0) == 1) begin
                issue(rand_alu(rd, prev1, prev2));
            end else begin
                issue(rand_alu(rd, prev2, prev1));   // Swapped onto the other read ports
            end
            prev2 = prev1;
            prev1 = rd;
        end
        finish_test(2, "forwarding", err0, chk0);

        err0 = errors;
        chk0 = checks;
        for (int n = 0; n < 40; n++) begin
            rd = 5'($urandom_range(8, 1));
            rj = ($urandom_range(2, 0) == 0) ? rd : 5'($urandom_range(8, 1));
            if ($urandom_range(1, 0) == 1) begin
                issue(enc_i(core_pkg::OPC_ADDI, rd, rj, 16'($urandom_range(3, 0))));
            end
            issue(enc_i(($urandom_range(1, 0) == 1) ? core_pkg::OPC_BEQ : core_pkg::OPC_BNE,
                        rd, rj, 16'($urandom())));
            idle(1);
        end
        finish_test(3, "branches", err0, chk0);

        err0 = errors;
        chk0 = checks;
        for (int n = 0; n < 12; n++) begin
            rd = 5'($urandom_range(20, 11));
            issue(enc_i(core_pkg::OPC_BEQ, rd, rd, 16'($urandom())));   // Always taken
            if (n % 3 == 2) begin
                issue(enc_i(core_pkg::OPC_BNE, rd, 5'(rd + 1), 16'($urandom())));
            end else begin
                issue(enc_i(core_pkg::OPC_ADDI, 5'(rd + 1), rd, 16'($urandom())));
            end
            issue(enc_r(core_pkg::OPC_ADD, 5'(rd + 2), 5'(rd + 1), rd));
            idle(2);
            issue(enc_i(core_pkg::OPC_BNE, rd, rd, 16'($urandom())));   // Never taken
            issue(enc_i(core_pkg::OPC_ADDI, 5'(rd + 3), rd, 16'($urandom())));
            idle(2);
        end
        finish_test(4, "squash", err0, chk0);

        // r0 targets and undefined opcodes
        err0 = errors;
        chk0 = checks;
        for (int n = 0; n < 16; n++) begin
            issue(rand_alu(5'd0, 5'($urandom()), 5'($urandom())));
            issue(enc_r(core_pkg::OPC_OR, 5'd21, 5'd0, 5'd0));
            issue(enc_i((n % 2 == 0) ? 6'd0 : 6'($urandom_range(63, 32)),
                        5'($urandom()), 5'($urandom()), 16'($urandom())));
            issue(enc_i(6'h07, 5'($urandom()), 5'($urandom()), 16'($urandom())));
            issue(enc_r(core_pkg::OPC_ADD, 5'd22, 5'd21, 5'($urandom_range(31, 1))));
            idle(1);
        end
        finish_test(5, "r0_unknown", err0, chk0);

        $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
